//--- filelist.f
hw/rvCorePkg.sv
hw/rvDecode.sv
hw/rvRegFile.sv
hw/rvExecute.sv
hw/rvWriteback.sv
hw/rvCoreTop.sv
bench/tbRvCore.sv

//--- run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbRvCore -f filelist.f

output=$(./obj_dir/VtbRvCore) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'All tests passed!'; then
    exit 0
fi
echo "simulation did not pass"
exit 1

//--- bench/tbRvCore.sv
// testbench for the arithmetic pipeline: clock, reset, directed and random
// instructions, reference model and per-cycle output compare
module tbRvCore;
    timeunit 1ns;
    timeprecision 1ps;
    import rvCorePkg::*;

    localparam int numDirected = 9;
    localparam int numRandom   = 400;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        instrValid;
    logic [31:0] instr;
    logic        wbValid;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        hazard;
    logic        illegal;

    // model state
    logic [31:0] modelRegs [32];
    // destinations issued at the last three sampled edges, 0 for none
    logic [4:0]  hist [1:3];
    int          dueQ[$];
    logic [4:0]  rdQ[$];
    logic [31:0] dataQ[$];
    int          cycle = 0;
    logic        curValid = 1'b0;
    logic [31:0] curInstr = '0;
    // expected outputs after the latest edge
    logic        checkOn = 1'b0;
    logic        expWbValid = 1'b0;
    logic [4:0]  expWbAddr = '0;
    logic [31:0] expWbData = '0;
    logic        expHazard = 1'b0;
    logic        expIllegal = 1'b0;

    rvCoreTop UUT (
        .clk_i(clk_i), .rst_i(rst_i),
        .instrValid_i(instrValid), .instr_i(instr),
        .wbValid_o(wbValid), .wbAddr_o(wbAddr), .wbData_o(wbData),
        .hazard_o(hazard), .illegal_o(illegal)
    );

    always #50 clk_i = ~clk_i;

    // ------------------------------
    // encoders and reference model
    // ------------------------------
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // RV32I rules: funct7 only 0 or 0x20 where the ISA defines it
    function automatic logic isLegal(input logic [31:0] ins);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = ins[31:25];
        f3 = ins[14:12];
        if (ins[6:0] == OPC_OP)
            return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        if (ins[6:0] != OPC_OP_IMM)
            return 1'b0;
        if (f3 == 3'b001)
            return f7 == 7'h00;
        if (f3 == 3'b101)
            return f7 == 7'h00 || f7 == 7'h20;
        return 1'b1;
    endfunction

    // expected result of one legal instruction
    function automatic logic [31:0] aluRef(input logic [31:0] ins, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [31:0] opB;
        logic [4:0]  sh;
        opB = (ins[6:0] == OPC_OP_IMM) ? {{20{ins[31]}}, ins[31:20]} : b;
        sh  = opB[4:0];
        case (ins[14:12])
            3'b000:  return (ins[6:0] == OPC_OP && ins[30]) ? a - opB : a + opB;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
            3'b011:  return (a < opB) ? 32'd1 : 32'd0;
            3'b100:  return a ^ opB;
            3'b101:  return ins[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | opB;
            default: return a & opB;
        endcase
    endfunction

    function automatic logic srcInFlight(input logic [4:0] idx);
        return idx != 5'd0 && (idx == hist[1] || idx == hist[2] || idx == hist[3]);
    endfunction

    // ------------------------------
    // stimulus
    // ------------------------------
    // zero reads, x0 write, hazard at distance 3 then 4, illegal with no pending
    function automatic logic [32:0] directedInstr(input int idx);
        case (idx)
            0:       return {1'b1, encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd1)};
            1:       return {1'b1, encI(12'h055, 5'd0, 3'd0, 5'd0)};
            2:       return {1'b1, encI(12'hffd, 5'd0, 3'd0, 5'd2)};
            3:       return {1'b1, encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd3)};
            5:       return {1'b1, encR(7'h20, 5'd2, 5'd0, 3'd0, 5'd4)};
            6:       return {1'b1, encR(7'h20, 5'd2, 5'd0, 3'd0, 5'd4)};
            7:       return {1'b1, encR(7'h01, 5'd1, 5'd1, 3'd0, 5'd7)};
            8:       return {1'b1, encR(7'h00, 5'd0, 5'd7, 3'd0, 5'd1)};
            default: return '0;
        endcase
    endfunction

    // random OP or OP-IMM on x0..x7, some idle, some illegal
    function automatic logic [32:0] randomInstr();
        logic [31:0] sel;
        logic [31:0] rnd;
        logic [31:0] ins;
        logic [11:0] imm;
        logic [2:0]  f3;
        sel = $urandom();
        rnd = $urandom();
        if (sel[3:0] < 4'd2)
            return '0;
        f3 = rnd[11:9];
        if (rnd[12])
            ins = encR((rnd[13] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                       {2'b00, rnd[8:6]}, {2'b00, rnd[5:3]}, f3, {2'b00, rnd[2:0]});
        else
        begin
            imm = rnd[31:20];
            // shift immediates keep a legal upper field
            if (f3 == 3'b001)
                imm[11:5] = 7'h00;
            if (f3 == 3'b101)
                imm[11:5] = rnd[13] ? 7'h20 : 7'h00;
            ins = encI(imm, {2'b00, rnd[5:3]}, f3, {2'b00, rnd[2:0]});
        end
        if (sel[7:4] == 4'd0)
        begin
            case (sel[9:8])
                2'd0:    ins[6:0] = 7'b0000011;
                2'd1:    ins[6:0] = 7'b0110111;
                2'd2:    ins[6:0] = 7'b1100011;
                default: ins = {7'h01, ins[24:7], OPC_OP};
            endcase
        end
        return {1'b1, ins};
    endfunction

    // one edge: retire, classify the sampled instruction, drive the next
    // idx below zero drives idle
    task automatic stepCycle(input int idx);
        logic [32:0] nextWord;
        logic [31:0] ins;
        logic [4:0]  newRd;
        logic        busy;
        @(posedge clk_i);
        cycle++;
        expWbValid = 1'b0;
        if (dueQ.size() > 0 && dueQ[0] == cycle)
        begin
            void'(dueQ.pop_front());
            expWbValid = 1'b1;
            expWbAddr  = rdQ.pop_front();
            expWbData  = dataQ.pop_front();
            if (expWbAddr != 5'd0)
                modelRegs[expWbAddr] = expWbData;
        end
        expHazard  = 1'b0;
        expIllegal = 1'b0;
        newRd      = 5'd0;
        ins        = curInstr;
        if (curValid && !isLegal(ins))
            expIllegal = 1'b1;
        else if (curValid)
        begin
            busy = srcInFlight(ins[19:15]) ||
                   (ins[6:0] == OPC_OP && srcInFlight(ins[24:20]));
            if (busy)
                expHazard = 1'b1;
            else
            begin
                dueQ.push_back(cycle + 3);
                rdQ.push_back(ins[11:7]);
                dataQ.push_back(aluRef(ins, modelRegs[ins[19:15]], modelRegs[ins[24:20]]));
                newRd = ins[11:7];
            end
        end
        hist[3] = hist[2];
        hist[2] = hist[1];
        hist[1] = newRd;

        if (idx < 0)
            nextWord = '0;
        else if (idx < numDirected)
            nextWord = directedInstr(idx);
        else
            nextWord = randomInstr();
        // one scoreboard bit per register, so keep one rd off consecutive issues
        if (nextWord[32] && nextWord[11:7] != 5'd0 && nextWord[11:7] == hist[1])
            nextWord[11:7] = {2'b00, nextWord[9:7] + 3'd1};
        instrValid <= nextWord[32];
        instr      <= nextWord[31:0];
        curValid   = nextWord[32];
        curInstr   = nextWord[31:0];
    endtask

    // ------------------------------
    // compare
    // ------------------------------
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped on the first mismatch");
        end
    endtask

    // outputs settle after the rising edge, compare mid cycle
    always @(negedge clk_i)
    begin
        if (checkOn)
        begin
            checkValue("wbValid_o", {31'b0, expWbValid}, {31'b0, wbValid});
            checkValue("hazard_o", {31'b0, expHazard}, {31'b0, hazard});
            checkValue("illegal_o", {31'b0, expIllegal}, {31'b0, illegal});
            if (expWbValid)
            begin
                checkValue("wbAddr_o", {27'b0, expWbAddr}, {27'b0, wbAddr});
                checkValue("wbData_o", expWbData, wbData);
            end
        end
    end

    initial
    begin
        int waited;
        void'($urandom(32'hca46));
        rst_i      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        for (int i = 1; i <= 3; i++)
            hist[i] = 5'd0;
        // outputs must already be low during reset
        @(posedge clk_i);
        checkOn = 1'b1;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;

        for (int i = 0; i < numDirected + numRandom; i++)
            stepCycle(i);

        // drain, idle input, last driven instruction still to be sampled
        waited = 0;
        while (dueQ.size() > 0 || curValid)
        begin
            if (waited >= 10)
            begin
                $display("pipeline did not drain within 10 cycles");
                $display("Test failures found");
                $fatal(1, "drain timeout");
            end
            stepCycle(-1);
            waited++;
        end
        stepCycle(-1);
        stepCycle(-1);

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- hw/rvCoreTop.sv
// pipeline top: decode, register file, execute, writeback
module rvCoreTop #(
    parameter int numRegs = 32
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             instrValid_i,
    input  logic [rvCorePkg::XLEN-1:0]       instr_i,
    output logic                             wbValid_o,
    output logic [rvCorePkg::REG_ADDR_W-1:0] wbAddr_o,
    output logic [rvCorePkg::XLEN-1:0]       wbData_o,
    output logic                             hazard_o,
    output logic                             illegal_o
);
    import rvCorePkg::*;

    // decode to register file
    logic [REG_ADDR_W-1:0] rs1Addr;
    logic [REG_ADDR_W-1:0] rs2Addr;
    logic                  rs2Used;
    logic                  hazard;
    // decode to execute, issue also feeds the scoreboard
    logic                  issue;
    logic [REG_ADDR_W-1:0] rdAddr;
    aluOpT                 aluOp;
    logic [XLEN-1:0]       imm;
    logic                  useImm;
    // read data
    logic [XLEN-1:0]       rdDataA;
    logic [XLEN-1:0]       rdDataB;
    // execute to writeback
    logic                  exValid;
    logic [REG_ADDR_W-1:0] exRd;
    logic [XLEN-1:0]       exResult;
    // writeback to register file
    logic                  wrEn;
    logic [REG_ADDR_W-1:0] wrAddr;
    logic [XLEN-1:0]       wrData;

    rvDecode #(.numRegs(numRegs)) decode (
        .clk_i(clk_i), .rst_i(rst_i),
        .instrValid_i(instrValid_i), .instr_i(instr_i),
        .rs1Addr_o(rs1Addr), .rs2Addr_o(rs2Addr), .rs2Used_o(rs2Used),
        .hazard_i(hazard),
        .issue_o(issue), .rdAddr_o(rdAddr), .aluOp_o(aluOp),
        .imm_o(imm), .useImm_o(useImm),
        .hazard_o(hazard_o), .illegal_o(illegal_o)
    );

    rvRegFile #(.numRegs(numRegs)) regFile (
        .clk_i(clk_i), .rst_i(rst_i),
        .rs1Addr_i(rs1Addr), .rs2Addr_i(rs2Addr), .rs2Used_i(rs2Used),
        .hazard_o(hazard),
        .issue_i(issue), .issueRd_i(rdAddr),
        .wrEn_i(wrEn), .wrAddr_i(wrAddr), .wrData_i(wrData),
        .rdDataA_o(rdDataA), .rdDataB_o(rdDataB)
    );

    rvExecute execute (
        .clk_i(clk_i), .rst_i(rst_i),
        .valid_i(issue), .rd_i(rdAddr), .aluOp_i(aluOp),
        .imm_i(imm), .useImm_i(useImm),
        .rdDataA_i(rdDataA), .rdDataB_i(rdDataB),
        .valid_o(exValid), .rd_o(exRd), .result_o(exResult)
    );

    rvWriteback writeback (
        .clk_i(clk_i), .rst_i(rst_i),
        .valid_i(exValid), .rd_i(exRd), .result_i(exResult),
        .wrEn_o(wrEn), .wrAddr_o(wrAddr), .wrData_o(wrData),
        .wbValid_o(wbValid_o), .wbAddr_o(wbAddr_o), .wbData_o(wbData_o)
    );

endmodule

//--- hw/rvWriteback.sv
// writeback stage: retire register feeding the
// register file write port and the result port
module rvWriteback (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             valid_i,
    input  logic [rvCorePkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rvCorePkg::XLEN-1:0]       result_i,
    output logic                             wrEn_o,
    output logic [rvCorePkg::REG_ADDR_W-1:0] wrAddr_o,
    output logic [rvCorePkg::XLEN-1:0]       wrData_o,
    output logic                             wbValid_o,
    output logic [rvCorePkg::REG_ADDR_W-1:0] wbAddr_o,
    output logic [rvCorePkg::XLEN-1:0]       wbData_o
);
    import rvCorePkg::*;

    logic                  validQ;
    logic [REG_ADDR_W-1:0] rdQ;
    logic [XLEN-1:0]       dataQ;

    // retire register
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            validQ <= 1'b0;
        else
            validQ <= valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        rdQ   <= rd_i;
        dataQ <= result_i;
    end

    // ------------------------------
    // both ports from one register
    // ------------------------------
    // x0 result still reported, never written
    assign wrEn_o    = validQ && (rdQ != '0);
    assign wrAddr_o  = rdQ;
    assign wrData_o  = dataQ;
    assign wbValid_o = validQ;
    assign wbAddr_o  = rdQ;
    assign wbData_o  = dataQ;

endmodule

//--- hw/rvExecute.sv
// execute stage: operand alignment and registered ALU
// for the arithmetic and shift operations
module rvExecute (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             valid_i,
    input  logic [rvCorePkg::REG_ADDR_W-1:0] rd_i,
    input  rvCorePkg::aluOpT                 aluOp_i,
    input  logic [rvCorePkg::XLEN-1:0]       imm_i,
    input  logic                             useImm_i,
    input  logic [rvCorePkg::XLEN-1:0]       rdDataA_i,
    input  logic [rvCorePkg::XLEN-1:0]       rdDataB_i,
    output logic                             valid_o,
    output logic [rvCorePkg::REG_ADDR_W-1:0] rd_o,
    output logic [rvCorePkg::XLEN-1:0]       result_o
);
    import rvCorePkg::*;

    // control held one edge while the register file reads
    logic                  validQ;
    logic [REG_ADDR_W-1:0] rdQ;
    aluOpT                 aluOpQ;
    logic [XLEN-1:0]       immQ;
    logic                  useImmQ;
    logic [XLEN-1:0]       opB;
    logic [4:0]            shamt;
    logic [XLEN-1:0]       aluOut;

    // ------------------------------
    // alignment stage
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            validQ <= 1'b0;
        else
            validQ <= valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        rdQ     <= rd_i;
        aluOpQ  <= aluOp_i;
        immQ    <= imm_i;
        useImmQ <= useImm_i;
    end

    // ------------------------------
    // ALU
    // ------------------------------
    assign opB   = useImmQ ? immQ : rdDataB_i;
    // shift amount from the low bits only
    assign shamt = opB[4:0];

    always_comb
    begin
        case (aluOpQ)
            ALU_ADD:  aluOut = rdDataA_i + opB;
            ALU_SUB:  aluOut = rdDataA_i - opB;
            ALU_SLL:  aluOut = rdDataA_i << shamt;
            ALU_SLT:  aluOut = {{(XLEN-1){1'b0}}, $signed(rdDataA_i) < $signed(opB)};
            ALU_SLTU: aluOut = {{(XLEN-1){1'b0}}, rdDataA_i < opB};
            ALU_XOR:  aluOut = rdDataA_i ^ opB;
            ALU_SRL:  aluOut = rdDataA_i >> shamt;
            ALU_SRA:  aluOut = $unsigned($signed(rdDataA_i) >>> shamt);
            ALU_OR:   aluOut = rdDataA_i | opB;
            default:  aluOut = rdDataA_i & opB;
        endcase
    end

    // result register
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            valid_o <= 1'b0;
        else
            valid_o <= validQ;
    end

    always_ff @(posedge clk_i)
    begin
        rd_o     <= rdQ;
        result_o <= aluOut;
    end

endmodule

//--- hw/rvRegFile.sv
// register array with registered reads, write port
// and the pending-write scoreboard
module rvRegFile #(
    parameter int numRegs = 32
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic [rvCorePkg::REG_ADDR_W-1:0] rs1Addr_i,
    input  logic [rvCorePkg::REG_ADDR_W-1:0] rs2Addr_i,
    input  logic                             rs2Used_i,
    output logic                             hazard_o,
    input  logic                             issue_i,
    input  logic [rvCorePkg::REG_ADDR_W-1:0] issueRd_i,
    input  logic                             wrEn_i,
    input  logic [rvCorePkg::REG_ADDR_W-1:0] wrAddr_i,
    input  logic [rvCorePkg::XLEN-1:0]       wrData_i,
    output logic [rvCorePkg::XLEN-1:0]       rdDataA_o,
    output logic [rvCorePkg::XLEN-1:0]       rdDataB_o
);
    import rvCorePkg::*;

    logic [XLEN-1:0]       regs [numRegs];
    // one bit per register with a write in flight
    logic [numRegs-1:0]    pendingQ;
    // read indices, captured at the issue edge
    logic [REG_ADDR_W-1:0] idxAQ;
    logic [REG_ADDR_W-1:0] idxBQ;
    // retire tracking, two stages behind the issue strobe
    logic                  rtValid1Q;
    logic                  rtValid2Q;
    logic [REG_ADDR_W-1:0] rtRd1Q;
    logic [REG_ADDR_W-1:0] rtRd2Q;

    // source busy: pending bit or the op issued last edge
    function automatic logic srcBusy(input logic [REG_ADDR_W-1:0] idx,
                                     input logic [numRegs-1:0]    pend,
                                     input logic                  newIssue,
                                     input logic [REG_ADDR_W-1:0] newRd);
        logic hit;
        hit = 1'b0;
        if (idx != '0 && int'(idx) < numRegs)
            hit = pend[idx] || (newIssue && newRd == idx);
        return hit;
    endfunction

    // ------------------------------
    // hazard from the incoming sources
    // ------------------------------
    assign hazard_o = srcBusy(rs1Addr_i, pendingQ, issue_i, issueRd_i) ||
                      (rs2Used_i && srcBusy(rs2Addr_i, pendingQ, issue_i, issueRd_i));

    // ------------------------------
    // scoreboard
    // ------------------------------
    // bit set one edge after issue, covered meanwhile by the
    // issue_i term above; cleared three edges after the sample
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pendingQ  <= '0;
            rtValid1Q <= 1'b0;
            rtValid2Q <= 1'b0;
        end
        else
        begin
            rtValid1Q <= issue_i && issueRd_i != '0;
            rtValid2Q <= rtValid1Q;
            if (rtValid2Q)
                pendingQ[rtRd2Q] <= 1'b0;
            // a fresh set on the same index overrides the clear
            if (issue_i && issueRd_i != '0)
                pendingQ[issueRd_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        rtRd1Q <= issueRd_i;
        rtRd2Q <= rtRd1Q;
    end

    // ------------------------------
    // array write, x0 stays zero
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end
        else if (wrEn_i && wrAddr_i != '0)
            regs[wrAddr_i] <= wrData_i;
    end

    // registered read, one edge after issue
    always_ff @(posedge clk_i)
    begin
        idxAQ     <= rs1Addr_i;
        idxBQ     <= rs2Addr_i;
        rdDataA_o <= (int'(idxAQ) < numRegs) ? regs[idxAQ] : '0;
        rdDataB_o <= (int'(idxBQ) < numRegs) ? regs[idxBQ] : '0;
    end

    // every retiring write was marked pending until its retire edge
    assert property (@(posedge clk_i) disable iff (rst_i)
        wrEn_i |-> |($past(pendingQ) & ({{(numRegs-1){1'b0}}, 1'b1} << wrAddr_i)))
        else $error("write to a register with no pending bit");

endmodule

//--- hw/rvDecode.sv
// decode stage: field split, legality check, hazard drop
// and the issue register feeding execute
module rvDecode #(
    parameter int numRegs = 32
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             instrValid_i,
    input  logic [rvCorePkg::XLEN-1:0]       instr_i,
    output logic [rvCorePkg::REG_ADDR_W-1:0] rs1Addr_o,
    output logic [rvCorePkg::REG_ADDR_W-1:0] rs2Addr_o,
    output logic                             rs2Used_o,
    input  logic                             hazard_i,
    output logic                             issue_o,
    output logic [rvCorePkg::REG_ADDR_W-1:0] rdAddr_o,
    output rvCorePkg::aluOpT                 aluOp_o,
    output logic [rvCorePkg::XLEN-1:0]       imm_o,
    output logic                             useImm_o,
    output logic                             hazard_o,
    output logic                             illegal_o
);
    import rvCorePkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic                  isOp;
    logic                  isOpImm;
    logic                  badFunct7;
    logic                  badIndex;
    logic                  illegal;
    aluOpT                 aluOp;

    // ------------------------------
    // field split
    // ------------------------------
    assign opcode  = instr_i[6:0];
    assign rd      = instr_i[11:7];
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign isOp    = (opcode == OPC_OP);
    assign isOpImm = (opcode == OPC_OP_IMM);

    // source indices go straight to the scoreboard
    assign rs1Addr_o = instr_i[19:15];
    assign rs2Addr_o = instr_i[24:20];
    // rs2 only read by register-register forms
    assign rs2Used_o = isOp;

    // funct7 legality
    always_comb
    begin
        badFunct7 = 1'b0;
        if (isOp)
            // alternate encoding only for SUB and SRA
            badFunct7 = !(funct7 == F7_BASE ||
                          (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)));
        else if (isOpImm && funct3 == F3_SLL)
            badFunct7 = (funct7 != F7_BASE);
        else if (isOpImm && funct3 == F3_SR)
            // shamt sits in the low bits, upper bits pick SRLI or SRAI
            badFunct7 = (funct7 != F7_BASE && funct7 != F7_ALT);
    end

    // indices past the configured register count, RV32E case
    assign badIndex = (int'(rd) >= numRegs) || (int'(rs1Addr_o) >= numRegs) ||
                      (isOp && int'(rs2Addr_o) >= numRegs);

    assign illegal = !(isOp || isOpImm) || badFunct7 || badIndex;

    // funct3/funct7 to ALU operation
    always_comb
    begin
        case (funct3)
            F3_ADD:  aluOp = (isOp && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            F3_SLL:  aluOp = ALU_SLL;
            F3_SLT:  aluOp = ALU_SLT;
            F3_SLTU: aluOp = ALU_SLTU;
            F3_XOR:  aluOp = ALU_XOR;
            F3_SR:   aluOp = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:   aluOp = ALU_OR;
            default: aluOp = ALU_AND;
        endcase
    end

    // ------------------------------
    // outcome pulses, illegal before hazard
    // ------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            issue_o   <= 1'b0;
            hazard_o  <= 1'b0;
            illegal_o <= 1'b0;
        end
        else
        begin
            issue_o   <= instrValid_i && !illegal && !hazard_i;
            hazard_o  <= instrValid_i && !illegal && hazard_i;
            illegal_o <= instrValid_i && illegal;
        end
    end

    // operation payload, qualified by issue_o downstream
    always_ff @(posedge clk_i)
    begin
        rdAddr_o <= rd;
        aluOp_o  <= aluOp;
        // I-immediate, sign extended
        imm_o    <= {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
        useImm_o <= isOpImm;
    end

    // one outcome per sampled instruction
    assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({issue_o, hazard_o, illegal_o}))
        else $error("decode raised more than one outcome");

endmodule

//--- hw/rvCorePkg.sv
// widths, major opcodes, funct fields and ALU operation codes
// shared by the RV32I arithmetic pipeline
package rvCorePkg;

    // data path width
    localparam int XLEN = 32;

    // register index width, fixed by the instruction format
    localparam int REG_ADDR_W = 5;

    // ------------------------------
    // major opcodes
    // ------------------------------
    // register-register arithmetic
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    // register-immediate arithmetic
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct7 values, base and alternate (SUB, SRA, SRAI)
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // funct3 values of the arithmetic group
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // ------------------------------
    // ALU operations, decode to execute
    // ------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } aluOpT;

endpackage
